/* source/cache_pkg.sv */
package cache_pkg;

    // processor side
    localparam int word_bits = 32;
    localparam int addr_bits = 30;

    // geometry, 8 lines of 4 words
    localparam int offset_bits    = 2;
    localparam int index_bits     = 3;
    localparam int tag_bits       = addr_bits - index_bits - offset_bits;
    localparam int num_lines      = 1 << index_bits;
    localparam int words_per_line = 1 << offset_bits;

    // memory side moves whole lines
    localparam int line_bits      = word_bits * words_per_line;
    localparam int line_addr_bits = addr_bits - offset_bits;

    // same word address seen as lookup fields or as a memory line address
    typedef union packed {
        struct packed {
            logic [tag_bits-1:0]    tag;
            logic [index_bits-1:0]  index;
            logic [offset_bits-1:0] offset;
        } parts;
        struct packed {
            logic [line_addr_bits-1:0] line_addr;
            logic [offset_bits-1:0]    offset;
        } line;
    } word_addr_u;

    typedef enum logic [1:0] {
        lookup,
        write_back,
        refill,
        done
    } ctrl_state_e;

endpackage

/* source/cache_req_capture.sv */
`timescale 1ns/100ps

module cache_req_capture (
    input  logic                              clk,
    input  logic                              proc_reset,
    input  logic                              proc_read,
    input  logic                              proc_write,
    input  logic [cache_pkg::addr_bits-1:0]   proc_addr,
    input  logic [cache_pkg::word_bits-1:0]   proc_wdata,
    input  logic                              req_done,
    output logic                              req_valid,
    output logic                              req_write,
    output cache_pkg::word_addr_u             req_addr,
    output logic [cache_pkg::word_bits-1:0]   req_wdata
);

    logic load;

    // only an empty slot takes a new request
    assign load = !req_valid && (proc_read || proc_write);

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset)
            req_valid <= 1'b0;
        else if (load)
            req_valid <= 1'b1;
        else if (req_done)
            req_valid <= 1'b0;
    end

    // fields stay put while the controller works on them
    always_ff @(posedge clk) begin
        if (load) begin
            req_write <= proc_write;
            req_addr  <= proc_addr;
            req_wdata <= proc_wdata;
        end
    end

    a_one_strobe: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(proc_read && proc_write)
    );

    // controller retires only a request that was captured
    a_done_has_req: assert property (
        @(posedge clk) disable iff (proc_reset)
        req_done |-> req_valid
    );

endmodule

/* source/cache_line_store.sv */
`timescale 1ns/100ps

module cache_line_store (
    input  logic                              clk,
    input  logic                              proc_reset,
    input  cache_pkg::word_addr_u             req_addr,
    input  logic [cache_pkg::word_bits-1:0]   req_wdata,
    input  logic [cache_pkg::line_bits-1:0]   mem_rdata,
    input  logic                              word_we,
    input  logic                              fill_we,
    output logic                              line_hit,
    output logic                              line_dirty,
    output logic [cache_pkg::tag_bits-1:0]    line_tag,
    output logic [cache_pkg::line_bits-1:0]   line_data
);

    logic [cache_pkg::line_bits-1:0]   data_mem [cache_pkg::num_lines];
    logic [cache_pkg::tag_bits-1:0]    tag_mem  [cache_pkg::num_lines];
    logic [cache_pkg::num_lines-1:0]   valid_bits;
    logic [cache_pkg::num_lines-1:0]   dirty_bits;
    logic [cache_pkg::index_bits-1:0]  idx;
    logic [cache_pkg::offset_bits-1:0] off;

    assign idx = req_addr.parts.index;
    assign off = req_addr.parts.offset;

    // indexed line, read out combinationally
    assign line_tag   = tag_mem[idx];
    assign line_data  = data_mem[idx];
    assign line_dirty = dirty_bits[idx];
    assign line_hit   = valid_bits[idx] && (tag_mem[idx] == req_addr.parts.tag);

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (fill_we) begin
            // fresh copy from memory is clean
            valid_bits[idx] <= 1'b1;
            dirty_bits[idx] <= 1'b0;
        end else if (word_we) begin
            dirty_bits[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            data_mem[idx] <= mem_rdata;
            tag_mem[idx]  <= req_addr.parts.tag;
        end else if (word_we) begin
            data_mem[idx][off*cache_pkg::word_bits +: cache_pkg::word_bits] <= req_wdata;
        end
    end

    a_we_exclusive: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(word_we && fill_we)
    );

    // request is held across the refill, so the next lookup must hit
    a_fill_hits: assert property (
        @(posedge clk) disable iff (proc_reset)
        fill_we |=> line_hit
    );

endmodule

/* source/cache_controller.sv */
`timescale 1ns/100ps

module cache_controller (
    input  logic                                 clk,
    input  logic                                 proc_reset,
    input  logic                                 req_valid,
    input  logic                                 req_write,
    input  cache_pkg::word_addr_u                req_addr,
    input  logic                                 line_hit,
    input  logic                                 line_dirty,
    input  logic [cache_pkg::tag_bits-1:0]       line_tag,
    input  logic [cache_pkg::line_bits-1:0]      line_data,
    input  logic                                 mem_ready,
    output logic                                 req_done,
    output logic                                 word_we,
    output logic                                 fill_we,
    output logic                                 mem_read,
    output logic                                 mem_write,
    output logic [cache_pkg::line_addr_bits-1:0] mem_addr,
    output logic [cache_pkg::line_bits-1:0]      mem_wdata,
    output logic                                 proc_stall,
    output logic [cache_pkg::word_bits-1:0]      proc_rdata
);

    cache_pkg::ctrl_state_e state;
    cache_pkg::ctrl_state_e state_next;
    logic                   hit_now;

    assign hit_now = (state == cache_pkg::lookup) && req_valid && line_hit;

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset)
            state <= cache_pkg::lookup;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::lookup: begin
                if (req_valid) begin
                    if (line_hit)
                        state_next = cache_pkg::done;
                    else if (line_dirty)
                        state_next = cache_pkg::write_back;
                    else
                        state_next = cache_pkg::refill;
                end
            end
            cache_pkg::write_back: begin
                if (mem_ready)
                    state_next = cache_pkg::refill;
            end
            // back to lookup after the fill, which then hits
            cache_pkg::refill: begin
                if (mem_ready)
                    state_next = cache_pkg::lookup;
            end
            cache_pkg::done: begin
                state_next = cache_pkg::lookup;
            end
            default: begin
                state_next = cache_pkg::lookup;
            end
        endcase
    end

    // strobes held until ready is seen at an edge
    assign mem_write = (state == cache_pkg::write_back);
    assign mem_read  = (state == cache_pkg::refill);
    assign fill_we   = mem_read && mem_ready;

    // victim goes out under its own tag
    assign mem_addr  = mem_write ? {line_tag, req_addr.parts.index}
                                 : req_addr.line.line_addr;
    assign mem_wdata = line_data;

    assign req_done   = (state == cache_pkg::done);
    assign word_we    = req_done && req_write;
    assign proc_stall = !req_done;

    // loaded on the hit so the word is there while stall is low
    always_ff @(posedge clk) begin
        if (hit_now)
            proc_rdata <= line_data[req_addr.parts.offset*cache_pkg::word_bits
                                    +: cache_pkg::word_bits];
    end

    a_mem_one_strobe: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(mem_read && mem_write)
    );

    // refill request stays put until memory answers
    a_read_held: assert property (
        @(posedge clk) disable iff (proc_reset)
        (mem_read && !mem_ready) |=> (mem_read && $stable(mem_addr))
    );

endmodule

/* source/cache_top.sv */
`timescale 1ns/100ps

module cache_top (
    input  logic                                 clk,
    input  logic                                 proc_reset,
    input  logic                                 proc_read,
    input  logic                                 proc_write,
    input  logic [cache_pkg::addr_bits-1:0]      proc_addr,
    input  logic [cache_pkg::word_bits-1:0]      proc_wdata,
    output logic                                 proc_stall,
    output logic [cache_pkg::word_bits-1:0]      proc_rdata,
    output logic                                 mem_read,
    output logic                                 mem_write,
    output logic [cache_pkg::line_addr_bits-1:0] mem_addr,
    input  logic [cache_pkg::line_bits-1:0]      mem_rdata,
    output logic [cache_pkg::line_bits-1:0]      mem_wdata,
    input  logic                                 mem_ready
);

    // captured request
    logic                            req_valid;
    logic                            req_write;
    cache_pkg::word_addr_u           req_addr;
    logic [cache_pkg::word_bits-1:0] req_wdata;
    logic                            req_done;

    // indexed line and its update strobes
    logic                            line_hit;
    logic                            line_dirty;
    logic [cache_pkg::tag_bits-1:0]  line_tag;
    logic [cache_pkg::line_bits-1:0] line_data;
    logic                            word_we;
    logic                            fill_we;

    cache_req_capture cache_req_capture_inst (
        .*
    );

    cache_line_store cache_line_store_inst (
        .*
    );

    cache_controller cache_controller_inst (
        .*
    );

endmodule

/* dv/cache_tb_checks.svh */
task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "stopping at first failure");
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
        $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        abort_run();
    end
endtask

task automatic check_word(input string name, input logic [cache_pkg::word_bits-1:0] exp,
                          input logic [cache_pkg::word_bits-1:0] act);
    if (exp !== act) begin
        $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        abort_run();
    end
endtask

task automatic check_line_addr(input string name,
                               input logic [cache_pkg::line_addr_bits-1:0] exp,
                               input logic [cache_pkg::line_addr_bits-1:0] act);
    if (exp !== act) begin
        $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        abort_run();
    end
endtask

task automatic check_line(input string name, input logic [cache_pkg::line_bits-1:0] exp,
                          input logic [cache_pkg::line_bits-1:0] act);
    if (exp !== act) begin
        $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        abort_run();
    end
endtask

task automatic expect_cond(input bit ok, input string what);
    if (!ok) begin
        $display("Check failed at %0t ns: %s", $time, what);
        abort_run();
    end
endtask

// called on a falling edge, returns on the falling edge after stall drops
task automatic access(input logic wr, input logic [29:0] addr, input logic [31:0] data);
    proc_read = !wr;
    proc_write = wr;
    proc_addr = addr;
    proc_wdata = data;
    cur_read = !wr;
    cur_addr = addr;
    if (wr)
        shadow[addr[5:0]] = data;
    @(posedge clk);
    while (proc_stall)
        @(posedge clk);
    @(negedge clk);
    // stall is low for one cycle only
    check_flag("proc_stall", 1'b1, proc_stall);
    proc_read = 1'b0;
    proc_write = 1'b0;
    cur_read = 1'b0;
endtask

task automatic run_directed();
    int reads_before;
    int writes_before;
    check_flag("proc_stall", 1'b1, proc_stall);
    check_flag("mem_read", 1'b0, mem_read);
    check_flag("mem_write", 1'b0, mem_write);
    reads_before = read_count;
    writes_before = write_count;
    // cold miss, line 1
    access(1'b0, 30'h05, '0);
    expect_cond(read_count == reads_before + 1, "cold read did not fetch the line");
    check_line_addr("mem_addr", 28'h1, last_read_addr);
    // same line, other word
    access(1'b0, 30'h07, '0);
    expect_cond(read_count == reads_before + 1, "read hit went to memory");
    access(1'b1, 30'h05, 32'hdead_beef);
    access(1'b0, 30'h05, '0);
    expect_cond(write_count == writes_before, "write hit was written through");
    // line 9 shares index 1, dirty line 1 goes out first
    access(1'b0, 30'h24, '0);
    expect_cond(write_count == writes_before + 1, "dirty victim was not written back");
    check_line_addr("mem_addr", 28'h1, last_write_addr);
    check_line("mem_wdata", expected_line(28'h1), last_write_data);
    expect_cond(read_count == reads_before + 2, "conflict miss did not refill");
    check_line_addr("mem_addr", 28'h9, last_read_addr);
endtask

task automatic run_random();
    logic [31:0] r;
    logic [31:0] d;
    repeat (200) begin
        r = $random(seed);
        d = $random(seed);
        access(r[0], {24'b0, r[6:1]}, d);
    end
endtask

/* dv/cache_tb.sv */
`timescale 1ns/100ps

module cache_tb;

    // directed accesses plus the random run
    localparam int num_requests = 205;
    localparam int num_words    = 64;

    logic                                 clk;
    logic                                 proc_reset;
    logic                                 proc_read;
    logic                                 proc_write;
    logic [cache_pkg::addr_bits-1:0]      proc_addr;
    logic [cache_pkg::word_bits-1:0]      proc_wdata;
    logic                                 proc_stall;
    logic [cache_pkg::word_bits-1:0]      proc_rdata;
    logic                                 mem_read;
    logic                                 mem_write;
    logic [cache_pkg::line_addr_bits-1:0] mem_addr;
    logic [cache_pkg::line_bits-1:0]      mem_rdata;
    logic [cache_pkg::line_bits-1:0]      mem_wdata;
    logic                                 mem_ready;

    logic [cache_pkg::line_bits-1:0]      mem_lines [16];
    logic [cache_pkg::word_bits-1:0]      shadow [num_words];
    logic [cache_pkg::line_addr_bits-1:0] last_read_addr;
    logic [cache_pkg::line_addr_bits-1:0] last_write_addr;
    logic [cache_pkg::line_bits-1:0]      last_write_data;
    logic                                 cur_read;
    logic [cache_pkg::addr_bits-1:0]      cur_addr;
    integer                               seed;
    int                                   mem_delay;
    int                                   read_count;
    int                                   write_count;

    cache_top cache_top_inst (.*);

    `include "cache_tb_checks.svh"

    always #50 clk = ~clk;

    function automatic logic [31:0] fill_word(input int a);
        return 32'h1f2e_3d4c ^ (a * 32'h0101_0101);
    endfunction

    function automatic logic [31:0] expected_word(input logic [29:0] addr);
        return shadow[addr[5:0]];
    endfunction

    // words in offset order, offset 0 at the bottom
    function automatic logic [127:0] expected_line(input logic [27:0] line_addr);
        logic [127:0] l;
        int           o;
        for (o = 0; o < 4; o++)
            l[o*32 +: 32] = shadow[{line_addr[3:0], o[1:0]}];
        return l;
    endfunction

    // memory model, one ready pulse per held strobe
    always begin
        @(negedge clk);
        if (mem_read || mem_write) begin
            mem_delay = 1 + ({$random(seed)} % 4);
            repeat (mem_delay - 1) @(negedge clk);
            if (mem_write) begin
                mem_lines[mem_addr[3:0]] = mem_wdata;
                last_write_addr = mem_addr;
                last_write_data = mem_wdata;
                write_count++;
            end else begin
                mem_rdata = mem_lines[mem_addr[3:0]];
                last_read_addr = mem_addr;
                read_count++;
            end
            mem_ready = 1'b1;
            @(negedge clk);
            mem_ready = 1'b0;
        end
    end

    // read data is only valid in the cycle stall is low
    always @(posedge clk) begin
        if (!proc_reset && !proc_stall && cur_read) begin
            check_word("proc_rdata", expected_word(cur_addr), proc_rdata);
        end
    end

    initial begin
        repeat (num_requests * 20 + 100) @(posedge clk);
        $display("Timeout: the cache stopped answering within %0d cycles",
                 num_requests * 20 + 100);
        abort_run();
    end

    initial begin
        clk = 1'b0;
        proc_reset = 1'b1;
        proc_read = 1'b0;
        proc_write = 1'b0;
        proc_addr = '0;
        proc_wdata = '0;
        mem_rdata = '0;
        mem_ready = 1'b0;
        cur_read = 1'b0;
        cur_addr = '0;
        seed = 32'hb8b8;
        read_count = 0;
        write_count = 0;
        for (int w = 0; w < num_words; w++) begin
            shadow[w] = fill_word(w);
            mem_lines[w / 4][(w % 4)*32 +: 32] = fill_word(w);
        end
        repeat (10) @(negedge clk);
        proc_reset = 1'b0;
        run_directed();
        run_random();
        $display("All tests passed!");
        $finish;
    end

endmodule

/* tb.f */
+incdir+dv
source/cache_pkg.sv
source/cache_req_capture.sv
source/cache_line_store.sv
source/cache_controller.sv
source/cache_top.sv
dv/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module cache_tb -f tb.f -o cache_tb_sim &&
    { ./obj_dir/cache_tb_sim > sim.log 2>&1; cat sim.log; } ||
    { echo "build failed"; exit 1; }
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
